// File: sources.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/writeback_unit.sv
verilog/rv_core_top.sv
bench/core_checker.sv
bench/core_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = core_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
PASS     = *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS)'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_config.svh"

module core_tb;

    localparam int num_tests    = 5;
    localparam int prog_len     = 48;
    localparam int tail_len     = 8;
    localparam int mem_words    = prog_len + tail_len;
    localparam int cycle_budget = num_tests * prog_len * 12;

    logic               clk;
    logic               rst;
    logic               ifu_rvalid;
    rv_core_pkg::word_t ifu_rdata;
    logic               ifu_req;
    rv_core_pkg::word_t ifu_addr;
    logic               commit_valid;
    rv_core_pkg::word_t commit_pc;
    logic [4:0]         commit_rd;
    rv_core_pkg::word_t commit_data;
    logic               ebreak_flag;
    rv_core_pkg::word_t exit_code;
    rv_core_pkg::word_t retired_count;
    logic               end_check;
    int                 errors;
    int                 commits;
    int                 failed;
    int                 delay;
    rv_core_pkg::word_t req_addr;
    rv_core_pkg::word_t prog [mem_words];
    logic [4:0]         last_rd [2];

    rv_core_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .ifu_rvalid    (ifu_rvalid),
        .ifu_rdata     (ifu_rdata),
        .ifu_req       (ifu_req),
        .ifu_addr      (ifu_addr),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_rd     (commit_rd),
        .commit_data   (commit_data),
        .ebreak_flag   (ebreak_flag),
        .exit_code     (exit_code),
        .retired_count (retired_count)
    );

    core_checker chk0 (
        .clk           (clk),
        .rst           (rst),
        .ifu_req       (ifu_req),
        .ifu_addr      (ifu_addr),
        .ifu_rvalid    (ifu_rvalid),
        .ifu_rdata     (ifu_rdata),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .commit_rd     (commit_rd),
        .commit_data   (commit_data),
        .ebreak_flag   (ebreak_flag),
        .exit_code     (exit_code),
        .retired_count (retired_count),
        .end_check     (end_check),
        .errors        (errors),
        .commits       (commits)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic rv_core_pkg::word_t reg_reg_inst(input logic [6:0] f7,
        input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
        input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_core_pkg::word_t reg_imm_inst(input logic [11:0] imm,
        input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic rv_core_pkg::word_t upper_inst(input logic [19:0] imm,
        input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // Small register range keeps reuse and hazards frequent
    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(0, 15));
    endfunction

    function automatic string test_name(input int mode);
        case (mode)
            0: return "reg-reg";
            1: return "reg-imm";
            2: return "upper-imm";
            3: return "dep-chain";
            default: return "mixed";
        endcase
    endfunction

    function automatic rv_core_pkg::word_t random_inst(input int mode, input logic [4:0] rd,
        input logic [4:0] rs1, input logic [4:0] rs2);
        int                 r;
        int                 kind;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [11:0]        imm;
        rv_core_pkg::word_t bits;
        r    = $urandom_range(0, 9);
        bits = $urandom;
        f3   = bits[14:12];
        f7   = bits[31] ? 7'h20 : 7'h00;
        imm  = bits[11:0];
        // Kind 0 reg-reg, 1 reg-imm, 2 LUI, 3 AUIPC
        case (mode)
            0: kind = (r < 6) ? 0 : (r < 8) ? 1 : 2;
            1: kind = (r < 7) ? 1 : (r < 9) ? 2 : 0;
            2: kind = (r < 4) ? 3 : (r < 7) ? 2 : 1;
            default: kind = (r < 4) ? 0 : (r < 7) ? 1 : (r < 9) ? 2 : 3;
        endcase
        case (kind)
            0: begin
                if (f3 != 3'b000 && f3 != 3'b101) begin
                    f7 = 7'h00;
                end
                return reg_reg_inst(f7, f3, rd, rs1, rs2);
            end
            1: begin
                if (f3 == 3'b001) begin
                    imm = {7'h00, bits[24:20]};
                end else if (f3 == 3'b101) begin
                    imm = {f7, bits[24:20]};
                end
                return reg_imm_inst(imm, f3, rd, rs1);
            end
            2: return upper_inst(bits[31:12], rd, 7'b0110111);
            default: return upper_inst(bits[31:12], rd, 7'b0010111);
        endcase
    endfunction

    task automatic build_program(input int mode);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        last_rd[0] = 5'd1;
        last_rd[1] = 5'd2;
        for (int i = 0; i < prog_len - 1; i++) begin
            rd  = pick_reg();
            rs1 = pick_reg();
            rs2 = pick_reg();
            if (mode == 3) begin
                rd  = 5'($urandom_range(1, 15));
                rs1 = last_rd[0];
                rs2 = last_rd[$urandom_range(0, 1)];
            end
            prog[i]    = random_inst(mode, rd, rs1, rs2);
            last_rd[1] = last_rd[0];
            last_rd[0] = rd;
        end
        prog[prog_len - 1] = `RV_EBREAK_INST;
        // Words fetched past EBREAK never retire
        for (int i = prog_len; i < mem_words; i++) begin
            prog[i] = random_inst(4, pick_reg(), pick_reg(), pick_reg());
        end
    endtask

    function automatic rv_core_pkg::word_t mem_word(input rv_core_pkg::word_t addr);
        rv_core_pkg::word_t offset;
        offset = addr - `RV_RESET_PC;
        if (offset[1:0] == 2'b00 && offset < mem_words * 4) begin
            return prog[int'(offset >> 2)];
        end
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
    endfunction

    // Instruction memory answers in 1 to 4 cycles
    always begin
        @(negedge clk);
        ifu_rvalid = 1'b0;
        if (!rst && ifu_req) begin
            req_addr = ifu_addr;
            delay    = $urandom_range(1, 4);
            repeat (delay) @(negedge clk);
            ifu_rvalid = 1'b1;
            ifu_rdata  = mem_word(req_addr);
        end
    end

    task automatic run_test(input int mode);
        int errors_before;
        @(negedge clk);
        rst = 1'b1;
        build_program(mode);
        repeat (3) @(negedge clk);
        rst           = 1'b0;
        errors_before = errors;
        wait (ebreak_flag === 1'b1);
        // Room for any stray commit after the halt
        repeat (12) @(negedge clk);
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        $display("test %0d %s: %0d commits, %0d errors", mode, test_name(mode), commits,
                 errors - errors_before);
        if (errors != errors_before) begin
            failed++;
        end
    endtask

    initial begin
        void'($urandom(32'he1f17609));
        rst        = 1'b1;
        ifu_rvalid = 1'b0;
        ifu_rdata  = '0;
        end_check  = 1'b0;
        failed     = 0;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d check errors", num_tests,
                 num_tests - failed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (cycle_budget) @(posedge clk);
        $display("watchdog expired after %0d cycles before all programs halted", cycle_budget);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/core_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_config.svh"

module core_checker (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               ifu_req,
    input  wire rv_core_pkg::word_t ifu_addr,
    input  wire logic               ifu_rvalid,
    input  wire rv_core_pkg::word_t ifu_rdata,
    input  wire logic               commit_valid,
    input  wire rv_core_pkg::word_t commit_pc,
    input  wire logic [4:0]         commit_rd,
    input  wire rv_core_pkg::word_t commit_data,
    input  wire logic               ebreak_flag,
    input  wire rv_core_pkg::word_t exit_code,
    input  wire rv_core_pkg::word_t retired_count,
    input  wire logic               end_check,
    output int                      errors,
    output int                      commits
);

    rv_core_pkg::word_t fetched [$];
    rv_core_pkg::word_t model_regs [32];
    rv_core_pkg::word_t model_pc;
    rv_core_pkg::word_t model_exit;
    rv_core_pkg::word_t fetch_addr;
    logic               fetch_busy;
    logic               model_halted;
    logic               end_done;

    // The alt flag selects SUB or SRA
    function automatic rv_core_pkg::word_t alu(input logic [2:0] f3, input logic alt,
        input rv_core_pkg::word_t a, input rv_core_pkg::word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic retire_one();
        rv_core_pkg::word_t inst;
        rv_core_pkg::word_t a;
        rv_core_pkg::word_t b;
        rv_core_pkg::word_t imm;
        rv_core_pkg::word_t value;
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [4:0]         rd;
        logic               writes;
        inst   = fetched.pop_front();
        opc    = inst[6:0];
        rd     = inst[11:7];
        f3     = inst[14:12];
        f7     = inst[31:25];
        a      = model_regs[inst[19:15]];
        b      = model_regs[inst[24:20]];
        imm    = {{20{inst[31]}}, inst[31:20]};
        writes = 1'b0;
        value  = '0;
        if (opc == 7'h33 && (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))) begin
            writes = 1'b1;
            value  = alu(f3, f7[5], a, b);
        end else if (opc == 7'h13 && !(f3 == 3'd1 && f7 != 7'h00)
                     && !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
            writes = 1'b1;
            value  = alu(f3, f3 == 3'd5 && f7[5], a, imm);
        end else if (opc == 7'h37) begin
            writes = 1'b1;
            value  = {inst[31:12], 12'b0};
        end else if (opc == 7'h17) begin
            writes = 1'b1;
            value  = model_pc + {inst[31:12], 12'b0};
        end
        if (commit_pc !== model_pc) begin
            $display("error commit_pc: got %h expected %h", commit_pc, model_pc);
            errors++;
        end
        if (writes && rd != 5'd0) begin
            if (commit_rd !== rd) begin
                $display("error commit_rd at pc %h: got %h expected %h", model_pc, commit_rd, rd);
                errors++;
            end
            if (commit_data !== value) begin
                $display("error commit_data at pc %h: got %h expected %h", model_pc,
                         commit_data, value);
                errors++;
            end
            model_regs[rd] = value;
        end
        if (inst == `RV_EBREAK_INST) begin
            model_halted = 1'b1;
            model_exit   = model_regs[`RV_EXIT_REG];
        end
        model_pc = model_pc + 32'd4;
        commits++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            fetched.delete();
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            model_pc     = `RV_RESET_PC;
            model_exit   = '0;
            fetch_addr   = `RV_RESET_PC;
            fetch_busy   = 1'b0;
            model_halted = 1'b0;
            end_done     = 1'b0;
            commits      = 0;
        end else begin
            // Straight-line program, so requests walk up by one word each
            if (ifu_req) begin
                if (fetch_busy) begin
                    $display("fetch request at %h issued while another fetch was outstanding",
                             ifu_addr);
                    errors++;
                end
                if (ifu_addr !== fetch_addr) begin
                    $display("error ifu_addr: got %h expected %h", ifu_addr, fetch_addr);
                    errors++;
                end
                fetch_addr = fetch_addr + 32'd4;
            end
            fetch_busy = ifu_req || (fetch_busy && !ifu_rvalid);
            if (ifu_rvalid) begin
                fetched.push_back(ifu_rdata);
            end
            if (commit_valid) begin
                if (model_halted) begin
                    $display("commit at pc %h came after EBREAK had already retired", commit_pc);
                    errors++;
                end else if (fetched.size() == 0) begin
                    $display("commit at pc %h has no fetched instruction behind it", commit_pc);
                    errors++;
                end else begin
                    retire_one();
                end
            end
            if (end_check && !end_done) begin
                end_done = 1'b1;
                if (!ebreak_flag || !model_halted) begin
                    $display("the program ended without a retired EBREAK");
                    errors++;
                end
                if (exit_code !== model_exit) begin
                    $display("error exit_code: got %h expected %h", exit_code, model_exit);
                    errors++;
                end
                if (retired_count !== rv_core_pkg::word_t'(commits)) begin
                    $display("error retired_count: got %h expected %h", retired_count,
                             rv_core_pkg::word_t'(commits));
                    errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  ifu_rvalid,
    input  wire rv_core_pkg::word_t    ifu_rdata,
    output logic                       ifu_req,
    output rv_core_pkg::word_t         ifu_addr,
    output logic                       commit_valid,
    output rv_core_pkg::word_t         commit_pc,
    output rv_core_pkg::reg_idx_t      commit_rd,
    output rv_core_pkg::word_t         commit_data,
    output logic                       ebreak_flag,
    output rv_core_pkg::word_t         exit_code,
    output rv_core_pkg::word_t         retired_count
);

    logic                     stall;
    logic                     halted;
    logic                     if_valid;
    rv_core_pkg::fetch_pkt_t  if_pkt;
    rv_core_pkg::reg_idx_t    rs1_addr;
    rv_core_pkg::reg_idx_t    rs2_addr;
    rv_core_pkg::word_t       rs1_data;
    rv_core_pkg::word_t       rs2_data;
    logic                     ex_valid;
    rv_core_pkg::issue_pkt_t  ex_pkt;
    logic                     wb_valid;
    rv_core_pkg::retire_pkt_t wb_pkt;
    logic                     rf_wen;
    rv_core_pkg::reg_idx_t    rf_waddr;
    rv_core_pkg::word_t       rf_wdata;

    fetch_unit u_fetch (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .halted     (halted),
        .ifu_rvalid (ifu_rvalid),
        .ifu_rdata  (ifu_rdata),
        .ifu_req    (ifu_req),
        .ifu_addr   (ifu_addr),
        .if_valid   (if_valid),
        .if_pkt     (if_pkt)
    );

    decode_unit u_decode (
        .clk      (clk),
        .rst      (rst),
        .if_valid (if_valid),
        .if_pkt   (if_pkt),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_valid (wb_valid),
        .wb_pkt   (wb_pkt),
        .stall    (stall),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .ex_valid (ex_valid),
        .ex_pkt   (ex_pkt)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rf_wen   (rf_wen),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_unit u_execute (
        .clk      (clk),
        .rst      (rst),
        .ex_valid (ex_valid),
        .ex_pkt   (ex_pkt),
        .wb_valid (wb_valid),
        .wb_pkt   (wb_pkt)
    );

    writeback_unit u_writeback (
        .clk           (clk),
        .rst           (rst),
        .wb_valid      (wb_valid),
        .wb_pkt        (wb_pkt),
        .rf_wen        (rf_wen),
        .rf_waddr      (rf_waddr),
        .rf_wdata      (rf_wdata),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .halted        (halted),
        .exit_code     (exit_code),
        .retired_count (retired_count)
    );

    // Commit port mirrors the register file write
    assign commit_rd   = rf_waddr;
    assign commit_data = rf_wdata;
    assign ebreak_flag = halted;

endmodule

`default_nettype wire

// File: verilog/writeback_unit.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_unit (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     wb_valid,
    input  wire rv_core_pkg::retire_pkt_t wb_pkt,
    output logic                          rf_wen,
    output rv_core_pkg::reg_idx_t         rf_waddr,
    output rv_core_pkg::word_t            rf_wdata,
    output logic                          commit_valid,
    output rv_core_pkg::word_t            commit_pc,
    output logic                          halted,
    output rv_core_pkg::word_t            exit_code,
    output rv_core_pkg::word_t            retired_count
);

    // Nothing commits once the core has halted
    assign commit_valid = wb_valid && !halted;
    assign commit_pc    = wb_pkt.pc;
    assign rf_wen       = commit_valid && wb_pkt.wen;
    assign rf_waddr     = wb_pkt.rd;
    assign rf_wdata     = wb_pkt.result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halted        <= 1'b0;
            exit_code     <= '0;
            retired_count <= '0;
        end else if (commit_valid) begin
            retired_count <= retired_count + 32'd1;
            if (wb_pkt.ebreak) begin
                halted    <= 1'b1;
                exit_code <= wb_pkt.result;
            end
        end
    end

    a_quiet_after_halt: assert property (
        @(posedge clk) disable iff (rst)
        (commit_valid && wb_pkt.ebreak) |=> (halted && !commit_valid)
    ) else $error("commit seen after EBREAK halted the core");

endmodule

`default_nettype wire

// File: verilog/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    ex_valid,
    input  wire rv_core_pkg::issue_pkt_t ex_pkt,
    output logic                         wb_valid,
    output rv_core_pkg::retire_pkt_t     wb_pkt
);

    rv_core_pkg::word_t a;
    rv_core_pkg::word_t b;
    logic [4:0]         shamt;
    rv_core_pkg::word_t alu_y;
    rv_core_pkg::word_t result;

    assign a     = ex_pkt.op_a;
    assign b     = ex_pkt.op_b;
    assign shamt = b[4:0];

    always_comb begin
        case (ex_pkt.op)
            rv_core_pkg::alu_add:  alu_y = a + b;
            rv_core_pkg::alu_sub:  alu_y = a - b;
            rv_core_pkg::alu_and:  alu_y = a & b;
            rv_core_pkg::alu_or:   alu_y = a | b;
            rv_core_pkg::alu_xor:  alu_y = a ^ b;
            rv_core_pkg::alu_slt:  alu_y = rv_core_pkg::word_t'($signed(a) < $signed(b));
            rv_core_pkg::alu_sltu: alu_y = rv_core_pkg::word_t'(a < b);
            rv_core_pkg::alu_sll:  alu_y = a << shamt;
            rv_core_pkg::alu_srl:  alu_y = a >> shamt;
            rv_core_pkg::alu_sra:  alu_y = $signed(a) >>> shamt;
            default:               alu_y = b;
        endcase
    end

    // EBREAK carries a0 through as its result
    assign result = ex_pkt.ebreak ? a : alu_y;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
        end
    end

    // EX/WB payload
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_pkt.pc     <= ex_pkt.pc;
            wb_pkt.rd     <= ex_pkt.rd;
            wb_pkt.wen    <= ex_pkt.wen;
            wb_pkt.result <= result;
            wb_pkt.ebreak <= ex_pkt.ebreak;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_config.svh"

module reg_file (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rv_core_pkg::reg_idx_t rs1_addr,
    input  wire rv_core_pkg::reg_idx_t rs2_addr,
    input  wire logic                  rf_wen,
    input  wire rv_core_pkg::reg_idx_t rf_waddr,
    input  wire rv_core_pkg::word_t    rf_wdata,
    output rv_core_pkg::word_t         rs1_data,
    output rv_core_pkg::word_t         rs2_data
);

    rv_core_pkg::word_t regs [`RV_NUM_REGS];

    // x0 always reads zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wen && rf_waddr != '0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    a_no_x0_target: assert property (
        @(posedge clk) disable iff (rst)
        rf_wen |-> (rf_waddr != '0)
    ) else $error("register file write aimed at x0");

endmodule

`default_nettype wire

// File: verilog/decode_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_config.svh"

module decode_unit (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     if_valid,
    input  wire rv_core_pkg::fetch_pkt_t  if_pkt,
    input  wire rv_core_pkg::word_t       rs1_data,
    input  wire rv_core_pkg::word_t       rs2_data,
    input  wire logic                     wb_valid,
    input  wire rv_core_pkg::retire_pkt_t wb_pkt,
    output logic                          stall,
    output rv_core_pkg::reg_idx_t         rs1_addr,
    output rv_core_pkg::reg_idx_t         rs2_addr,
    output logic                          ex_valid,
    output rv_core_pkg::issue_pkt_t       ex_pkt
);

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    rv_core_pkg::word_t      inst;
    logic [6:0]              opcode;
    logic [2:0]              f3;
    logic [6:0]              f7;
    rv_core_pkg::reg_idx_t   rd;
    rv_core_pkg::word_t      imm_i;
    rv_core_pkg::word_t      imm_u;
    logic                    is_ebreak;
    logic                    use_rs1;
    logic                    use_rs2;
    logic                    wr;
    logic                    ex_wr;
    logic                    wb_wr;
    logic                    rs1_hazard;
    logic                    rs2_hazard;
    rv_core_pkg::issue_pkt_t id_pkt;

    assign inst      = if_pkt.inst;
    assign opcode    = inst[6:0];
    assign rd        = inst[11:7];
    assign f3        = inst[14:12];
    assign f7        = inst[31:25];
    assign imm_i     = {{20{inst[31]}}, inst[31:20]};
    assign imm_u     = {inst[31:12], 12'b0};
    assign is_ebreak = (inst == `RV_EBREAK_INST);

    // EBREAK reads a0 through the rs1 port
    assign rs1_addr = is_ebreak ? `RV_EXIT_REG : inst[19:15];
    assign rs2_addr = inst[24:20];

    always_comb begin
        use_rs1       = 1'b0;
        use_rs2       = 1'b0;
        wr            = 1'b0;
        id_pkt.pc     = if_pkt.pc;
        id_pkt.op     = rv_core_pkg::alu_add;
        id_pkt.op_a   = rs1_data;
        id_pkt.op_b   = rs2_data;
        id_pkt.rd     = rd;
        id_pkt.ebreak = 1'b0;
        case (opcode)
            opc_op: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                // Only SUB and SRA take funct7 0100000
                wr = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
                case (f3)
                    3'b000: id_pkt.op = f7[5] ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
                    3'b001: id_pkt.op = rv_core_pkg::alu_sll;
                    3'b010: id_pkt.op = rv_core_pkg::alu_slt;
                    3'b011: id_pkt.op = rv_core_pkg::alu_sltu;
                    3'b100: id_pkt.op = rv_core_pkg::alu_xor;
                    3'b101: id_pkt.op = f7[5] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
                    3'b110: id_pkt.op = rv_core_pkg::alu_or;
                    default: id_pkt.op = rv_core_pkg::alu_and;
                endcase
            end
            opc_op_imm: begin
                use_rs1     = 1'b1;
                wr          = 1'b1;
                id_pkt.op_b = imm_i;
                case (f3)
                    3'b000: id_pkt.op = rv_core_pkg::alu_add;
                    3'b001: begin
                        id_pkt.op = rv_core_pkg::alu_sll;
                        wr        = (f7 == 7'h00);
                    end
                    3'b010: id_pkt.op = rv_core_pkg::alu_slt;
                    3'b011: id_pkt.op = rv_core_pkg::alu_sltu;
                    3'b100: id_pkt.op = rv_core_pkg::alu_xor;
                    3'b101: begin
                        id_pkt.op = f7[5] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
                        wr        = (f7 == 7'h00) || (f7 == 7'h20);
                    end
                    3'b110: id_pkt.op = rv_core_pkg::alu_or;
                    default: id_pkt.op = rv_core_pkg::alu_and;
                endcase
            end
            opc_lui: begin
                wr          = 1'b1;
                id_pkt.op   = rv_core_pkg::alu_pass_b;
                id_pkt.op_b = imm_u;
            end
            opc_auipc: begin
                wr          = 1'b1;
                id_pkt.op_a = if_pkt.pc;
                id_pkt.op_b = imm_u;
            end
            default: begin
                // Anything else, EBREAK included, writes nothing
                use_rs1       = is_ebreak;
                id_pkt.ebreak = is_ebreak;
            end
        endcase
        id_pkt.wen = wr && (rd != '0);
    end

    // RAW check against ID/EX and EX/WB
    assign ex_wr = ex_valid && ex_pkt.wen;
    assign wb_wr = wb_valid && wb_pkt.wen;

    assign rs1_hazard = use_rs1 && (rs1_addr != '0) &&
                        ((ex_wr && ex_pkt.rd == rs1_addr) || (wb_wr && wb_pkt.rd == rs1_addr));
    assign rs2_hazard = use_rs2 && (rs2_addr != '0) &&
                        ((ex_wr && ex_pkt.rd == rs2_addr) || (wb_wr && wb_pkt.rd == rs2_addr));

    assign stall = if_valid && (rs1_hazard || rs2_hazard);

    // Bubble on stall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= if_valid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && !stall) begin
            ex_pkt <= id_pkt;
        end
    end

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst)
        (if_valid && !stall) |=> !(ex_pkt.wen && ex_pkt.rd == '0)
    ) else $error("ID/EX holds an enabled write to x0");

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_config.svh"

module fetch_unit (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    stall,
    input  wire logic                    halted,
    input  wire logic                    ifu_rvalid,
    input  wire rv_core_pkg::word_t      ifu_rdata,
    output logic                         ifu_req,
    output rv_core_pkg::word_t           ifu_addr,
    output logic                         if_valid,
    output rv_core_pkg::fetch_pkt_t      if_pkt
);

    rv_core_pkg::word_t pc;
    logic               waiting;
    logic               consume;

    // Decode takes the IF/ID entry this cycle
    assign consume  = if_valid && !stall;
    assign ifu_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= `RV_RESET_PC;
            waiting  <= 1'b0;
            ifu_req  <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            ifu_req <= 1'b0;

            if (consume) begin
                if_valid <= 1'b0;
            end

            if (waiting && ifu_rvalid) begin
                if_valid <= 1'b1;
                waiting  <= 1'b0;
                pc       <= pc + 32'd4;
            end

            // One fetch outstanding, and only when IF/ID has room
            if (!waiting && !halted && (!if_valid || consume)) begin
                ifu_req <= 1'b1;
                waiting <= 1'b1;
            end
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (waiting && ifu_rvalid) begin
            if_pkt.pc   <= pc;
            if_pkt.inst <= ifu_rdata;
        end
    end

    a_no_req_while_waiting: assert property (
        @(posedge clk) disable iff (rst)
        (waiting && !ifu_rvalid) |=> !ifu_req
    ) else $error("fetch request issued while a fetch is outstanding");

endmodule

`default_nettype wire

// File: verilog/rv_core_pkg.sv
`default_nettype none

`include "rv_core_config.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // pass_b serves LUI
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_pkt_t;

    // Operand A holds a0 for EBREAK
    typedef struct packed {
        word_t    pc;
        alu_op_e  op;
        word_t    op_a;
        word_t    op_b;
        reg_idx_t rd;
        logic     wen;
        logic     ebreak;
    } issue_pkt_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        logic     wen;
        word_t    result;
        logic     ebreak;
    } retire_pkt_t;

endpackage

`default_nettype wire

// File: verilog/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count
`define RV_NUM_REGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h3000_0000

// Full EBREAK word, SYSTEM opcode with imm 1
`define RV_EBREAK_INST 32'h0010_0073

// a0 carries the exit code
`define RV_EXIT_REG 5'd10

`endif
